/* design/beat_alloc_ctrl.sv */
// Reservation tracker for read beats, a FIFO with pointers and no storage.
// A grant reserves alloc_size slots at once; each drained beat frees one.
`timescale 1ns/1ps

module beat_alloc_ctrl #(
        parameter int DEPTH               = 64,
        parameter int ALMOST_FULL_MARGIN  = 4,
        parameter int ALMOST_EMPTY_MARGIN = 4,
        localparam int AW                 = $clog2(DEPTH)
) (
        input  logic                      axi_aclk,
        input  logic                      reset,
        input  logic                      alloc_valid,
        input  beat_buf_pkg::alloc_size_t alloc_size,
        input  logic                      alloc_enable,
        input  logic                      beat_release,
        output logic                      alloc_ready,
        output logic [AW:0]               space_free,
        output logic                      full,
        output logic                      almost_full,
        output logic                      empty,
        output logic                      almost_empty
);

        // Compare width wide enough for both the size and the free count
        localparam int CMP_W = ($bits(alloc_size) > AW + 1) ? $bits(alloc_size) : AW + 1;

        logic [AW:0] rsv_ptr;
        logic [AW:0] rel_ptr;
        logic [AW:0] rsv_count;
        logic        grant;

        // --------------------------------------------------
        // Grant rule
        // --------------------------------------------------
        // Whole block must fit, not just one slot
        assign alloc_ready = alloc_enable && (alloc_size != '0) &&
                             (CMP_W'(alloc_size) <= CMP_W'(space_free));
        assign grant       = alloc_valid && alloc_ready;

        // --------------------------------------------------
        // Pointer pair
        // --------------------------------------------------
        always_ff @(posedge axi_aclk) begin
                if (reset) begin
                        rsv_ptr <= '0;
                        rel_ptr <= '0;
                end else begin
                        // Size fits in AW+1 bits once the grant rule passed
                        if (grant)
                                rsv_ptr <= rsv_ptr + (AW+1)'(alloc_size);
                        if (beat_release)
                                rel_ptr <= rel_ptr + 1'b1;
                end
        end

        beat_fifo_ctrl #(
                .DEPTH               (DEPTH),
                .ALMOST_FULL_MARGIN  (ALMOST_FULL_MARGIN),
                .ALMOST_EMPTY_MARGIN (ALMOST_EMPTY_MARGIN)
        ) beat_fifo_ctrl_i (
                .wr_ptr       (rsv_ptr),
                .rd_ptr       (rel_ptr),
                .count        (rsv_count),
                .full         (full),
                .almost_full  (almost_full),
                .empty        (empty),
                .almost_empty (almost_empty)
        );

        // Unreserved slots
        assign space_free = (AW+1)'(DEPTH) - rsv_count;

        // --------------------------------------------------
        // Checks
        // --------------------------------------------------
        // Drain side may only free beats that were reserved
        a_no_release_when_empty: assert property (@(posedge axi_aclk) disable iff (reset)
                beat_release |-> !empty);
        // Requester never asks for an empty block
        a_size_nonzero: assert property (@(posedge axi_aclk) disable iff (reset)
                alloc_valid |-> (alloc_size != '0));

endmodule

/* design/beat_apb_regs.sv */
// APB slave for the beat buffer, no wait states.
// Holds the grant enable, reports space and flags, counts grants and drains.
`timescale 1ns/1ps

module beat_apb_regs #(
        parameter int DEPTH = 64,
        localparam int AW   = $clog2(DEPTH)
) (
        input  logic                               axi_aclk,
        input  logic                               reset,
        input  logic                               psel,
        input  logic                               penable,
        input  logic                               pwrite,
        input  logic [beat_buf_pkg::APB_ADDR_W-1:0] paddr,
        input  logic [beat_buf_pkg::APB_DATA_W-1:0] pwdata,
        input  logic [AW:0]                        space_free,
        input  logic                               full,
        input  logic                               almost_full,
        input  logic                               empty,
        input  logic                               almost_empty,
        input  logic                               grant,
        input  logic                               drain,
        output logic [beat_buf_pkg::APB_DATA_W-1:0] prdata,
        output logic                               pready,
        output logic                               pslverr,
        output logic                               alloc_enable
);

        import beat_buf_pkg::*;

        logic [CNT_W-1:0]      grant_cnt;
        logic [CNT_W-1:0]      drain_cnt;
        logic [APB_DATA_W-1:0] status_word;
        logic [APB_DATA_W-1:0] rd_mux;
        logic                  mapped;
        logic                  access;

        // Access phase of any transfer
        assign access = psel && penable;

        // --------------------------------------------------
        // Control register and event counters
        // --------------------------------------------------
        always_ff @(posedge axi_aclk) begin
                if (reset) begin
                        alloc_enable <= 1'b1;
                        grant_cnt    <= '0;
                        drain_cnt    <= '0;
                end else begin
                        // Only REG_CTRL takes writes
                        if (access && pwrite && (paddr == REG_CTRL))
                                alloc_enable <= pwdata[CTRL_EN_BIT];
                        if (grant)
                                grant_cnt <= grant_cnt + 1'b1;
                        if (drain)
                                drain_cnt <= drain_cnt + 1'b1;
                end
        end

        // Status word packing
        always_comb begin
                status_word                        = '0;
                status_word[STAT_FULL_BIT]         = full;
                status_word[STAT_ALMOST_FULL_BIT]  = almost_full;
                status_word[STAT_EMPTY_BIT]        = empty;
                status_word[STAT_ALMOST_EMPTY_BIT] = almost_empty;
        end

        // --------------------------------------------------
        // Address decode and read mux
        // --------------------------------------------------
        always_comb begin
                rd_mux = '0;
                mapped = 1'b1;
                case (paddr)
                        REG_CTRL:      rd_mux[CTRL_EN_BIT] = alloc_enable;
                        REG_STATUS:    rd_mux = status_word;
                        REG_SPACE:     rd_mux = APB_DATA_W'(space_free);
                        REG_ALLOC_CNT: rd_mux = APB_DATA_W'(grant_cnt);
                        REG_DRAIN_CNT: rd_mux = APB_DATA_W'(drain_cnt);
                        default:       mapped = 1'b0;
                endcase
        end

        // Read data valid in the access phase
        assign prdata  = rd_mux;
        // No wait states
        assign pready  = 1'b1;
        // Error on any unmapped access
        assign pslverr = access && !mapped;

        // Master must pass through setup before access
        a_penable_needs_psel: assert property (@(posedge axi_aclk) disable iff (reset)
                penable |-> psel);

endmodule

/* design/beat_buf_pkg.sv */
// Shared definitions for the read-beat reservation buffer.
// Holds the request size type, the APB register map and the field positions
// used by the register block and the top level.
package beat_buf_pkg;

        // Beats in one reservation request, 1 to 255
        typedef logic [7:0] alloc_size_t;

        // --------------------------------------------------
        // APB bus widths
        // --------------------------------------------------
        localparam int APB_ADDR_W = 12;
        localparam int APB_DATA_W = 32;

        // --------------------------------------------------
        // Register map
        // --------------------------------------------------
        localparam logic [APB_ADDR_W-1:0] REG_CTRL      = 12'h000;
        localparam logic [APB_ADDR_W-1:0] REG_STATUS    = 12'h004;
        localparam logic [APB_ADDR_W-1:0] REG_SPACE     = 12'h008;
        localparam logic [APB_ADDR_W-1:0] REG_ALLOC_CNT = 12'h00C;
        localparam logic [APB_ADDR_W-1:0] REG_DRAIN_CNT = 12'h010;

        // Event counter width, wraps on overflow
        localparam int CNT_W = 32;

        // REG_CTRL fields
        localparam int CTRL_EN_BIT = 0;

        // REG_STATUS fields
        localparam int STAT_FULL_BIT         = 0;
        localparam int STAT_ALMOST_FULL_BIT  = 1;
        localparam int STAT_EMPTY_BIT        = 2;
        localparam int STAT_ALMOST_EMPTY_BIT = 3;

endpackage

/* design/beat_buf_top.sv */
// Read-beat reservation buffer top level.
// Grants beat reservations, stores landed beats, releases a slot per drain.
`timescale 1ns/1ps

module beat_buf_top #(
        parameter int DEPTH               = 64,
        parameter int DATA_W              = 32,
        parameter int ALMOST_FULL_MARGIN  = 4,
        parameter int ALMOST_EMPTY_MARGIN = 4,
        localparam int AW                 = $clog2(DEPTH)
) (
        input  logic                               axi_aclk,
        input  logic                               reset,
        // Allocation port
        input  logic                               alloc_valid,
        input  beat_buf_pkg::alloc_size_t          alloc_size,
        output logic                               alloc_ready,
        // Landing port
        input  logic                               land_valid,
        input  logic [DATA_W-1:0]                  land_data,
        // Drain port
        output logic                               out_valid,
        output logic [DATA_W-1:0]                  out_data,
        input  logic                               out_ready,
        // APB slave
        input  logic                               psel,
        input  logic                               penable,
        input  logic                               pwrite,
        input  logic [beat_buf_pkg::APB_ADDR_W-1:0] paddr,
        input  logic [beat_buf_pkg::APB_DATA_W-1:0] pwdata,
        output logic [beat_buf_pkg::APB_DATA_W-1:0] prdata,
        output logic                               pready,
        output logic                               pslverr
);

        logic        grant;
        logic        drain;
        logic        alloc_enable;
        logic [AW:0] space_free;
        logic        full;
        logic        almost_full;
        logic        empty;
        logic        almost_empty;

        // --------------------------------------------------
        // Handshake pulses
        // --------------------------------------------------
        assign grant = alloc_valid && alloc_ready;
        assign drain = out_valid && out_ready;

        // Reservation bookkeeping
        beat_alloc_ctrl #(
                .DEPTH               (DEPTH),
                .ALMOST_FULL_MARGIN  (ALMOST_FULL_MARGIN),
                .ALMOST_EMPTY_MARGIN (ALMOST_EMPTY_MARGIN)
        ) beat_alloc_ctrl_i (
                .axi_aclk     (axi_aclk),
                .reset        (reset),
                .alloc_valid  (alloc_valid),
                .alloc_size   (alloc_size),
                .alloc_enable (alloc_enable),
                .beat_release (drain),
                .alloc_ready  (alloc_ready),
                .space_free   (space_free),
                .full         (full),
                .almost_full  (almost_full),
                .empty        (empty),
                .almost_empty (almost_empty)
        );

        // Landed beat storage
        beat_data_fifo #(
                .DEPTH  (DEPTH),
                .DATA_W (DATA_W)
        ) beat_data_fifo_i (
                .axi_aclk  (axi_aclk),
                .reset     (reset),
                .push      (land_valid),
                .push_data (land_data),
                .pop       (drain),
                .head_data (out_data),
                .not_empty (out_valid)
        );

        // Register block
        beat_apb_regs #(
                .DEPTH (DEPTH)
        ) beat_apb_regs_i (
                .axi_aclk     (axi_aclk),
                .reset        (reset),
                .psel         (psel),
                .penable      (penable),
                .pwrite       (pwrite),
                .paddr        (paddr),
                .pwdata       (pwdata),
                .space_free   (space_free),
                .full         (full),
                .almost_full  (almost_full),
                .empty        (empty),
                .almost_empty (almost_empty),
                .grant        (grant),
                .drain        (drain),
                .prdata       (prdata),
                .pready       (pready),
                .pslverr      (pslverr),
                .alloc_enable (alloc_enable)
        );

endmodule

/* design/beat_data_fifo.sv */
// Storage FIFO for landed read beats, show-ahead on the read side.
// head_data is the oldest beat whenever not_empty is high.
`timescale 1ns/1ps

module beat_data_fifo #(
        parameter int DEPTH  = 64,
        parameter int DATA_W = 32,
        localparam int AW    = $clog2(DEPTH)
) (
        input  logic              axi_aclk,
        input  logic              reset,
        input  logic              push,
        input  logic [DATA_W-1:0] push_data,
        input  logic              pop,
        output logic [DATA_W-1:0] head_data,
        output logic              not_empty
);

        logic [DATA_W-1:0] mem [DEPTH];
        logic [AW:0]       wr_ptr;
        logic [AW:0]       rd_ptr;
        logic              full;
        logic              empty;
        logic              do_push;
        logic              do_pop;

        // Guard the pointers against misuse
        assign do_push = push && !full;
        assign do_pop  = pop && !empty;

        // --------------------------------------------------
        // Pointers
        // --------------------------------------------------
        always_ff @(posedge axi_aclk) begin
                if (reset) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (do_push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (do_pop)
                                rd_ptr <= rd_ptr + 1'b1;
                end
        end

        // Storage array
        always_ff @(posedge axi_aclk) begin
                if (do_push)
                        mem[wr_ptr[AW-1:0]] <= push_data;
        end

        // Head of queue, read without a register stage
        assign head_data = mem[rd_ptr[AW-1:0]];
        assign not_empty = !empty;

        // Only full and empty matter here
        beat_fifo_ctrl #(
                .DEPTH               (DEPTH),
                .ALMOST_FULL_MARGIN  (1),
                .ALMOST_EMPTY_MARGIN (1)
        ) beat_fifo_ctrl_i (
                .wr_ptr       (wr_ptr),
                .rd_ptr       (rd_ptr),
                .count        (),
                .full         (full),
                .almost_full  (),
                .empty        (empty),
                .almost_empty ()
        );

        // Reservations upstream must keep landings within capacity
        a_no_push_when_full: assert property (@(posedge axi_aclk) disable iff (reset)
                push |-> !full);

endmodule

/* design/beat_fifo_ctrl.sv */
// Occupancy and flag logic for a binary pointer pair.
// Pointers carry one extra wrap bit; shared by the allocation and data FIFOs.
`timescale 1ns/1ps

module beat_fifo_ctrl #(
        parameter int DEPTH               = 64,
        parameter int ALMOST_FULL_MARGIN  = 4,
        parameter int ALMOST_EMPTY_MARGIN = 4,
        localparam int AW                 = $clog2(DEPTH)
) (
        input  logic [AW:0] wr_ptr,
        input  logic [AW:0] rd_ptr,
        output logic [AW:0] count,
        output logic        full,
        output logic        almost_full,
        output logic        empty,
        output logic        almost_empty
);

        // --------------------------------------------------
        // Threshold constants at pointer width
        // --------------------------------------------------
        localparam logic [AW:0] DEPTH_V = (AW+1)'(DEPTH);
        localparam logic [AW:0] AF_LVL  = (AW+1)'(DEPTH - ALMOST_FULL_MARGIN);
        localparam logic [AW:0] AE_LVL  = (AW+1)'(ALMOST_EMPTY_MARGIN);

        // Modulo subtraction handles the wrap bit
        assign count = wr_ptr - rd_ptr;

        // --------------------------------------------------
        // Flags, purely combinational from the pointers
        // --------------------------------------------------
        assign full         = (count == DEPTH_V);
        assign empty        = (count == '0);
        // At or above DEPTH minus margin
        assign almost_full  = (count >= AF_LVL);
        // At or below the empty margin
        assign almost_empty = (count <= AE_LVL);

        // --------------------------------------------------
        // Checks
        // --------------------------------------------------
        // Writer must never run more than DEPTH ahead of the reader
        always_comb begin
                if (!$isunknown(count)) begin
                        assert (count <= DEPTH_V)
                                else $error("beat_fifo_ctrl: occupancy %0d above depth", count);
                end
        end

endmodule

/* flist.f */
design/beat_buf_pkg.sv
design/beat_fifo_ctrl.sv
design/beat_alloc_ctrl.sv
design/beat_data_fifo.sv
design/beat_apb_regs.sv
design/beat_buf_top.sv
tb/tb_clock_gen.sv
tb/beat_buf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the beat buffer testbench with Verilator; the result is read from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module beat_buf_tb \
        -o beat_buf_sim > sim.log 2>&1 &&
        ./obj_dir/beat_buf_sim >> sim.log 2>&1 ||
        echo "ERRORS FOUND" >> sim.log
if grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
        echo "Simulation failed, see sim.log"
        exit 1
fi
echo "Simulation passed"

/* tb/beat_buf_tb.sv */
// Testbench for the read-beat reservation buffer.
// Random reservations, landings and drains run against a model of reserved
// slots and landed beats; APB reads check space, flags and counters.
`timescale 1ns/1ps

module beat_buf_tb;

        import beat_buf_pkg::*;

        localparam int DEPTH         = 64;
        localparam int DATA_W        = 32;
        localparam int AF_MARGIN     = 4;
        localparam int AE_MARGIN     = 4;
        localparam int RESET_CYCLES  = 10;
        localparam int RAND_CYCLES   = 2000;
        localparam int BP_CYCLES     = 200;
        localparam int DRAIN_CYCLES  = 600;
        localparam int DIS_CYCLES    = 60;
        localparam int RESUME_CYCLES = 300;
        // Up to 5 APB transfers of 4 cycles every 16 traffic cycles
        localparam int APB_CYCLES    = (RAND_CYCLES + RESUME_CYCLES) / 16 * 20 + 200;
        localparam int TIMEOUT_CYCLES = RESET_CYCLES + RAND_CYCLES + BP_CYCLES +
                                        3 * DRAIN_CYCLES + DIS_CYCLES + RESUME_CYCLES +
                                        APB_CYCLES + 2000;

        logic              axi_aclk;
        logic              reset;
        logic              alloc_valid;
        alloc_size_t       alloc_size;
        logic              alloc_ready;
        logic              land_valid;
        logic [DATA_W-1:0] land_data;
        logic              out_valid;
        logic [DATA_W-1:0] out_data;
        logic              out_ready;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
        logic [APB_DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;

        // --------------------------------------------------
        // Reference model state
        // --------------------------------------------------
        integer            seed = 63665;
        int                reserved;
        int                outstanding;
        int                grant_count;
        int                drain_count;
        int                stall_seen;
        bit                ctrl_enable;
        bit                req_pending;
        logic [DATA_W-1:0] beat_q [$];

        tb_clock_gen #(.PERIOD_NS(100)) tb_clock_gen_i (.axi_aclk(axi_aclk));

        beat_buf_top #(
                .DEPTH               (DEPTH),
                .DATA_W              (DATA_W),
                .ALMOST_FULL_MARGIN  (AF_MARGIN),
                .ALMOST_EMPTY_MARGIN (AE_MARGIN)
        ) beat_buf_top_i (
                .axi_aclk    (axi_aclk),
                .reset       (reset),
                .alloc_valid (alloc_valid),
                .alloc_size  (alloc_size),
                .alloc_ready (alloc_ready),
                .land_valid  (land_valid),
                .land_data   (land_data),
                .out_valid   (out_valid),
                .out_data    (out_data),
                .out_ready   (out_ready),
                .psel        (psel),
                .penable     (penable),
                .pwrite      (pwrite),
                .paddr       (paddr),
                .pwdata      (pwdata),
                .prdata      (prdata),
                .pready      (pready),
                .pslverr     (pslverr)
        );

        // Uniform pick in lo..hi from the seeded stream
        function automatic int rand_range(input int lo, input int hi);
                int span;
                span = hi - lo + 1;
                return lo + int'($unsigned($random(seed)) % span);
        endfunction

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
                        $display("ERRORS FOUND");
                        $fatal(1, "value mismatch");
                end
        endtask

        // --------------------------------------------------
        // One traffic cycle driven on the falling edge
        // --------------------------------------------------
        // rdy_mode 0 holds out_ready low, 1 randomizes it, 2 holds it high
        task automatic step_cycle(input bit req_on, input int max_size, input int rdy_mode);
                bit exp_ready;
                bit do_grant;
                bit do_drain;
                bit do_land;
                @(negedge axi_aclk);
                // Pending request keeps its size until granted
                if (req_pending) begin
                        alloc_valid = 1'b1;
                end else begin
                        alloc_size  = alloc_size_t'(rand_range(1, max_size));
                        alloc_valid = req_on && (rand_range(0, 3) != 0);
                        req_pending = alloc_valid;
                end
                // Land only against reserved but not yet landed beats
                do_land    = (outstanding > 0) && (rand_range(0, 1) == 1);
                land_valid = do_land;
                land_data  = $random(seed);
                out_ready  = (rdy_mode == 2) || ((rdy_mode == 1) && (rand_range(0, 1) == 1));
                #10;
                exp_ready = ctrl_enable && (int'(alloc_size) <= DEPTH - reserved);
                check_value("alloc_ready", 32'(exp_ready), 32'(alloc_ready));
                check_value("out_valid", 32'(beat_q.size() != 0), 32'(out_valid));
                if (beat_q.size() != 0)
                        check_value("out_data", beat_q[0], out_data);
                if (alloc_valid && (int'(alloc_size) > DEPTH - reserved))
                        stall_seen = stall_seen + 1;
                do_grant = alloc_valid && exp_ready;
                do_drain = out_ready && (beat_q.size() != 0);
                @(posedge axi_aclk);
                if (do_drain) begin
                        void'(beat_q.pop_front());
                        reserved    = reserved - 1;
                        drain_count = drain_count + 1;
                end
                if (do_land) begin
                        beat_q.push_back(land_data);
                        outstanding = outstanding - 1;
                end
                if (do_grant) begin
                        reserved    = reserved + int'(alloc_size);
                        outstanding = outstanding + int'(alloc_size);
                        grant_count = grant_count + 1;
                        req_pending = 1'b0;
                end
        endtask

        // --------------------------------------------------
        // APB transfers with traffic idle
        // --------------------------------------------------
        task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                                output logic [APB_DATA_W-1:0] data, output logic err);
                @(negedge axi_aclk);
                alloc_valid = 1'b0;
                land_valid  = 1'b0;
                out_ready   = 1'b0;
                psel        = 1'b1;
                pwrite      = 1'b0;
                paddr       = addr;
                @(negedge axi_aclk);
                penable = 1'b1;
                #10;
                check_value("pready", 32'(1), 32'(pready));
                data = prdata;
                err  = pslverr;
                @(negedge axi_aclk);
                psel    = 1'b0;
                penable = 1'b0;
        endtask

        task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                                 input logic [APB_DATA_W-1:0] data);
                @(negedge axi_aclk);
                alloc_valid = 1'b0;
                land_valid  = 1'b0;
                out_ready   = 1'b0;
                psel        = 1'b1;
                pwrite      = 1'b1;
                paddr       = addr;
                pwdata      = data;
                @(negedge axi_aclk);
                penable = 1'b1;
                #10;
                check_value("write_pslverr", 32'(0), 32'(pslverr));
                @(negedge axi_aclk);
                psel    = 1'b0;
                penable = 1'b0;
                pwrite  = 1'b0;
        endtask

        // Space, flags by margin rules, and both event counters
        task automatic check_registers();
                logic [APB_DATA_W-1:0] rdata;
                logic                  rerr;
                logic [APB_DATA_W-1:0] exp_status;
                exp_status                        = '0;
                exp_status[STAT_FULL_BIT]         = (reserved == DEPTH);
                exp_status[STAT_ALMOST_FULL_BIT]  = (reserved >= DEPTH - AF_MARGIN);
                exp_status[STAT_EMPTY_BIT]        = (reserved == 0);
                exp_status[STAT_ALMOST_EMPTY_BIT] = (reserved <= AE_MARGIN);
                apb_read(REG_SPACE, rdata, rerr);
                check_value("reg_space", 32'(DEPTH - reserved), rdata);
                check_value("reg_space_err", 32'(0), 32'(rerr));
                apb_read(REG_STATUS, rdata, rerr);
                check_value("reg_status", exp_status, rdata);
                apb_read(REG_ALLOC_CNT, rdata, rerr);
                check_value("reg_alloc_cnt", 32'(grant_count), rdata);
                apb_read(REG_DRAIN_CNT, rdata, rerr);
                check_value("reg_drain_cnt", 32'(drain_count), rdata);
        endtask

        // Run out all reservations with the consumer always ready
        task automatic drain_all();
                int i;
                for (i = 0; (i < DRAIN_CYCLES) && (req_pending || (reserved != 0)); i++)
                        step_cycle(1'b0, 32, 2);
                check_value("drain_reserved", 32'(0), 32'(reserved));
                check_value("drain_pending", 32'(0), 32'(req_pending));
        endtask

        // Watchdog sized from the phase lengths
        initial begin
                repeat (TIMEOUT_CYCLES) @(posedge axi_aclk);
                $display("Timeout: the test did not finish in %0d cycles", TIMEOUT_CYCLES);
                $display("ERRORS FOUND");
                $fatal(1, "watchdog expired");
        end

        // --------------------------------------------------
        // Test sequence
        // --------------------------------------------------
        initial begin
                logic [APB_DATA_W-1:0] rdata;
                logic                  rerr;
                int                    i;
                int                    grants_before;
                reset       = 1'b1;
                alloc_valid = 1'b0;
                alloc_size  = alloc_size_t'(1);
                land_valid  = 1'b0;
                land_data   = '0;
                out_ready   = 1'b0;
                psel        = 1'b0;
                penable     = 1'b0;
                pwrite      = 1'b0;
                paddr       = '0;
                pwdata      = '0;
                reserved    = 0;
                outstanding = 0;
                grant_count = 0;
                drain_count = 0;
                stall_seen  = 0;
                ctrl_enable = 1'b1;
                req_pending = 1'b0;
                repeat (RESET_CYCLES) @(posedge axi_aclk);
                @(negedge axi_aclk);
                reset = 1'b0;
                check_value("reset_pslverr", 32'(0), 32'(pslverr));
                check_registers();

                // Mixed random traffic with periodic register checks
                for (i = 0; i < RAND_CYCLES; i++) begin
                        step_cycle(1'b1, 32, 1);
                        if ((i % 16 == 15) && !req_pending)
                                check_registers();
                end

                // Consumer stalled so reservations pile up until refused
                stall_seen = 0;
                for (i = 0; i < BP_CYCLES; i++)
                        step_cycle(1'b1, 32, 0);
                check_value("bp_stall_seen", 32'(1), 32'(stall_seen > 0));
                drain_all();
                check_registers();

                // Grants blocked for any size while disabled
                apb_write(REG_CTRL, 32'h0);
                ctrl_enable = 1'b0;
                apb_read(REG_CTRL, rdata, rerr);
                check_value("reg_ctrl_off", 32'h0, rdata);
                for (i = 0; i < DIS_CYCLES; i++)
                        step_cycle(1'b0, 255, 1);

                // Re-enable and expect new grants
                apb_write(REG_CTRL, 32'h1);
                ctrl_enable   = 1'b1;
                grants_before = grant_count;
                for (i = 0; i < RESUME_CYCLES; i++) begin
                        step_cycle(1'b1, 32, 1);
                        if ((i % 16 == 15) && !req_pending)
                                check_registers();
                end
                check_value("grants_resumed", 32'(1), 32'(grant_count > grants_before));

                drain_all();

                // Unmapped address
                apb_read(12'h020, rdata, rerr);
                check_value("unmapped_pslverr", 32'(1), 32'(rerr));

                check_registers();

                $display("NO ERRORS");
                $finish;
        end

endmodule

/* tb/tb_clock_gen.sv */
// Free-running clock source for the beat buffer testbench.
// Period is set in ns by PERIOD_NS and starts low at time zero.
`timescale 1ns/1ps

module tb_clock_gen #(
        parameter int PERIOD_NS = 100
) (
        output logic axi_aclk
);

        // Half period per toggle
        initial begin
                axi_aclk = 1'b0;
                forever #(PERIOD_NS / 2) axi_aclk = ~axi_aclk;
        end

endmodule
